// ==== dv/uart_tb.sv ====
`timescale 1ns/1ns

module uart_tb;

  localparam int n_tests = 8;

  localparam int src_loop = 0;
  localparam int src_drv  = 1;

  localparam int inj_none   = 0;
  localparam int inj_parity = 1;
  localparam int inj_stop   = 2;

  localparam int mode_word  = 0;
  localparam int mode_empty = 1;
  localparam int mode_burst = 2;

  logic                            clk;
  logic                            nrst;
  logic [uart_pkg::addr_width-1:0] paddr;
  logic                            psel;
  logic                            penable;
  logic                            pwrite;
  logic [31:0]                     pwdata;
  logic [31:0]                     prdata;
  logic                            pready;
  logic                            pslverr;
  logic                            rxd;
  logic                            txd;
  logic                            use_drv; // 1 selects the serial driver, 0 loops txd back
  logic                            drv_line;

  string       test_name [n_tests];
  int          period_tab [n_tests];
  logic        parity_tab [n_tests];
  int          src_tab [n_tests];
  int          inj_tab [n_tests];
  int          mode_tab [n_tests];
  logic [4:0]  exp_stat_tab [n_tests];
  int          cur_period;
  int          cycle_cnt;
  int          cycle_limit;
  int unsigned seed_val;

  assign rxd = use_drv ? drv_line : txd;

  uart_top i_dut (
    .clk     (clk),
    .nrst    (nrst),
    .paddr   (paddr),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .rxd     (rxd),
    .txd     (txd)
  );

  initial
  begin
    clk = 1'b0;
  end

  always #20 clk = ~clk;

  task automatic abort_run();
    $display("Some tests failed");
    $fatal(1, "stopping at the first error");
  endtask

  always @(posedge clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit != 0 && cycle_cnt >= cycle_limit)
    begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      abort_run();
    end
  end

  task automatic check_word(string name, uart_pkg::word_t exp, uart_pkg::word_t act);
    if (exp !== act)
    begin
      $display("Fail %s: expected %h, actual %h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_byte(string name, uart_pkg::byte_t exp, uart_pkg::byte_t act);
    if (exp !== act)
    begin
      $display("Fail %s: expected %h, actual %h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_bit(string name, logic exp, logic act);
    if (exp !== act)
    begin
      $display("Fail %s: expected %b, actual %b", name, exp, act);
      abort_run();
    end
  endtask

  task automatic apb_write(logic [uart_pkg::addr_width-1:0] addr, logic [31:0] data,
                           output logic err);
    @(negedge clk);
    paddr   = addr;
    pwdata  = data;
    pwrite  = 1'b1;
    psel    = 1'b1;
    penable = 1'b0;
    @(negedge clk);
    penable = 1'b1;
    #1 err = pslverr;
    @(posedge clk); // the register side effect lands here
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic apb_read(logic [uart_pkg::addr_width-1:0] addr, output logic [31:0] data,
                          output logic err);
    @(negedge clk);
    paddr   = addr;
    pwrite  = 1'b0;
    psel    = 1'b1;
    penable = 1'b0;
    @(negedge clk);
    penable = 1'b1;
    #1;
    data = prdata;
    err  = pslverr;
    @(posedge clk);
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  // one frame on drv_line, optionally with a flipped parity bit or a low stop bit
  task automatic send_frame(uart_pkg::byte_t b, int per, logic par_on, logic bad_par,
                            logic bad_stop);
    logic [10:0] bits;
    int          nbits;
    bits  = '1;
    nbits = 0;
    bits[nbits] = 1'b0;
    nbits++;
    for (int k = 0; k < uart_pkg::data_bits; k++)
    begin
      bits[nbits] = b[k];
      nbits++;
    end
    if (par_on)
    begin
      bits[nbits] = (^b) ^ bad_par; // even parity
      nbits++;
    end
    bits[nbits] = !bad_stop;
    nbits++;
    @(negedge clk);
    for (int k = 0; k < nbits; k++)
    begin
      drv_line = bits[k];
      repeat (per) @(negedge clk);
    end
    drv_line = 1'b1;
    repeat (2 * per) @(negedge clk);
  endtask

  function automatic uart_pkg::word_t pack4(uart_pkg::byte_t b0, uart_pkg::byte_t b1,
                                            uart_pkg::byte_t b2, uart_pkg::byte_t b3);
    return {b3, b2, b1, b0};
  endfunction

  task automatic wait_rx_avail();
    logic [31:0] st;
    logic        err;
    st = '0;
    while (!st[uart_pkg::stat_rx_avail])
      apb_read(uart_pkg::addr_status, st, err);
  endtask

  task automatic wait_line_idle();
    logic [31:0] st;
    logic        err;
    st = '1;
    while (st[uart_pkg::stat_tx_busy])
      apb_read(uart_pkg::addr_status, st, err);
    repeat (4 * cur_period) @(negedge clk);
  endtask

  task automatic send_tx_byte(string name, uart_pkg::byte_t b, logic exp_err);
    logic err;
    apb_write(uart_pkg::addr_txdata, {24'h0, b}, err);
    check_bit({name, " txdata pslverr"}, exp_err, err);
  endtask

  task automatic read_word(string name, uart_pkg::word_t exp);
    logic [31:0] data;
    logic        err;
    wait_rx_avail();
    apb_read(uart_pkg::addr_rxdata, data, err);
    check_bit({name, " rxdata pslverr"}, 1'b0, err);
    check_byte({name, " byte 0"}, exp[7:0], data[7:0]);
    check_word({name, " rxdata"}, exp, data);
  endtask

  task automatic run_word(int i);
    uart_pkg::byte_t b [4];
    logic [31:0]     st;
    logic            err;
    string           name;
    name = test_name[i];
    if (inj_tab[i] != inj_none)
    begin
      send_frame(uart_pkg::byte_t'($urandom()), period_tab[i], parity_tab[i],
                 inj_tab[i] == inj_parity, inj_tab[i] == inj_stop);
      apb_read(uart_pkg::addr_status, st, err);
      check_bit({name, " parity_err"}, exp_stat_tab[i][uart_pkg::stat_parity_err],
                st[uart_pkg::stat_parity_err]);
      check_bit({name, " frame_err"}, exp_stat_tab[i][uart_pkg::stat_frame_err],
                st[uart_pkg::stat_frame_err]);
      check_bit({name, " rx_avail after bad frame"}, 1'b0, st[uart_pkg::stat_rx_avail]);
    end
    for (int k = 0; k < 4; k++)
    begin
      b[k] = uart_pkg::byte_t'($urandom());
      if (src_tab[i] == src_loop)
        send_tx_byte(name, b[k], 1'b0);
      else
        send_frame(b[k], period_tab[i], parity_tab[i], 1'b0, 1'b0);
      if (src_tab[i] == src_drv && k == 2)
      begin
        apb_read(uart_pkg::addr_status, st, err);
        check_bit({name, " rx_avail after three bytes"}, 1'b0, st[uart_pkg::stat_rx_avail]);
      end
    end
    read_word(name, pack4(b[0], b[1], b[2], b[3]));
    apb_read(uart_pkg::addr_status, st, err);
    check_bit({name, " rx_avail after read"}, 1'b0, st[uart_pkg::stat_rx_avail]);
    check_bit({name, " parity_err sticky"}, exp_stat_tab[i][uart_pkg::stat_parity_err],
              st[uart_pkg::stat_parity_err]);
    check_bit({name, " frame_err sticky"}, exp_stat_tab[i][uart_pkg::stat_frame_err],
              st[uart_pkg::stat_frame_err]);
    if (inj_tab[i] != inj_none)
    begin
      apb_write(uart_pkg::addr_status, {27'h0, exp_stat_tab[i]}, err); // write 1 to clear
      apb_read(uart_pkg::addr_status, st, err);
      check_bit({name, " parity_err cleared"}, 1'b0, st[uart_pkg::stat_parity_err]);
      check_bit({name, " frame_err cleared"}, 1'b0, st[uart_pkg::stat_frame_err]);
    end
  endtask

  task automatic run_empty(int i);
    logic [31:0] data;
    logic        err;
    apb_read(uart_pkg::addr_rxdata, data, err);
    check_word({test_name[i], " rxdata"}, '0, data);
    check_bit({test_name[i], " pslverr"}, 1'b1, err);
    check_bit({test_name[i], " pready"}, 1'b1, pready);
  endtask

  task automatic run_burst(int i);
    uart_pkg::byte_t b [9];
    logic [31:0]     st;
    logic            err;
    string           name;
    name = test_name[i];
    for (int k = 0; k < 9; k++)
      b[k] = uart_pkg::byte_t'($urandom());
    // the first byte leaves for the transmitter, the next four fill the FIFO
    for (int k = 0; k < 5; k++)
      send_tx_byte(name, b[k], 1'b0);
    apb_read(uart_pkg::addr_status, st, err);
    check_bit({name, " tx_full"}, 1'b1, st[uart_pkg::stat_tx_full]);
    send_tx_byte(name, b[5], 1'b1);
    read_word(name, pack4(b[0], b[1], b[2], b[3]));
    for (int k = 6; k < 9; k++)
      send_tx_byte(name, b[k], 1'b0);
    read_word({name, " second"}, pack4(b[4], b[6], b[7], b[8])); // b[5] was dropped
  endtask

  task automatic set_entry(int idx, string name, int per, logic par, int src, int inj,
                           int mode, logic [4:0] exp_stat);
    test_name[idx]    = name;
    period_tab[idx]   = per;
    parity_tab[idx]   = par;
    src_tab[idx]      = src;
    inj_tab[idx]      = inj;
    mode_tab[idx]     = mode;
    exp_stat_tab[idx] = exp_stat;
  endtask

  task automatic load_table();
    set_entry(0, "loop_p16", 16, 1'b0, src_loop, inj_none, mode_word, 5'b00000);
    set_entry(1, "loop_parity_p16", 16, 1'b1, src_loop, inj_none, mode_word, 5'b00000);
    set_entry(2, "loop_parity_p4", 4, 1'b1, src_loop, inj_none, mode_word, 5'b00000);
    set_entry(3, "loop_p37", 37, 1'b0, src_loop, inj_none, mode_word, 5'b00000);
    set_entry(4, "drv_parity_err", 16, 1'b1, src_drv, inj_parity, mode_word, 5'b01000);
    set_entry(5, "drv_stop_err", 4, 1'b0, src_drv, inj_stop, mode_word, 5'b10000);
    set_entry(6, "empty_rx_read", 16, 1'b0, src_loop, inj_none, mode_empty, 5'b00000);
    set_entry(7, "tx_burst_p64", 64, 1'b0, src_loop, inj_none, mode_burst, 5'b00000);
  endtask

  // frames per entry times a padded frame length, plus bus and idle overhead
  function automatic int run_budget();
    int total;
    int frames;
    total = 200;
    for (int i = 0; i < n_tests; i++)
    begin
      case (mode_tab[i])
        mode_word:  frames = (inj_tab[i] != inj_none) ? 5 : 4;
        mode_burst: frames = 8;
        default:    frames = 0;
      endcase
      total += (frames * 16 + 8) * period_tab[i] + 400;
    end
    return total;
  endfunction

  initial
  begin
    logic err;
    nrst        = 1'b0;
    paddr       = '0;
    psel        = 1'b0;
    penable     = 1'b0;
    pwrite      = 1'b0;
    pwdata      = '0;
    drv_line    = 1'b1;
    use_drv     = 1'b1;
    cycle_cnt   = 0;
    cycle_limit = 0;
    cur_period  = 16;
    seed_val    = $urandom(48);
    load_table();
    cycle_limit = run_budget();
    repeat (10) @(negedge clk);
    nrst = 1'b1;
    repeat (5) @(negedge clk);
    for (int i = 0; i < n_tests; i++)
    begin
      wait_line_idle();
      use_drv = (src_tab[i] == src_drv);
      apb_write(uart_pkg::addr_period, period_tab[i], err);
      check_bit({test_name[i], " period pslverr"}, 1'b0, err);
      apb_write(uart_pkg::addr_ctrl, {31'h0, parity_tab[i]}, err);
      check_bit({test_name[i], " ctrl pslverr"}, 1'b0, err);
      cur_period = period_tab[i];
      case (mode_tab[i])
        mode_word:  run_word(i);
        mode_empty: run_empty(i);
        default:    run_burst(i);
      endcase
    end
    $display("All tests passed");
    $finish;
  end

endmodule

// ==== verilog.f ====
verilog/uart_pkg.sv
verilog/sync_fifo.sv
verilog/uart_rx.sv
verilog/uart_word_pack.sv
verilog/uart_tx.sv
verilog/uart_apb_regs.sv
verilog/uart_top.sv
dv/uart_tb.sv

// ==== verilog/sync_fifo.sv ====
`timescale 1ns/1ns

module sync_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int  depth     = 4
) (
  input  logic     clk,
  input  logic     nrst,
  input  logic     push,
  input  payload_t push_data,
  input  logic     pop,
  output payload_t pop_data,
  output logic     empty,
  output logic     full
);

  localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
  localparam int cnt_w = $clog2(depth + 1);

  payload_t mem [depth];

  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [cnt_w-1:0] count;
  logic             do_push;
  logic             do_pop;

  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  assign empty    = (count == '0);
  assign full     = (count == cnt_w'(depth));
  assign pop_data = mem[rd_ptr]; // head entry, valid while not empty

  always_ff @(posedge clk)
  begin
    if (do_push)
      mem[wr_ptr] <= push_data;
  end

  always_ff @(posedge clk)
  begin
    if (!nrst)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
      if (do_push && !do_pop)
        count <= count + 1'b1;
      else if (do_pop && !do_push)
        count <= count - 1'b1;
    end
  end

endmodule

// ==== verilog/uart_apb_regs.sv ====
`timescale 1ns/1ns

module uart_apb_regs (
  input  logic                              clk,
  input  logic                              nrst,
  input  logic [uart_pkg::addr_width-1:0]   paddr,
  input  logic                              psel,
  input  logic                              penable,
  input  logic                              pwrite,
  input  logic [31:0]                       pwdata,
  output logic [31:0]                       prdata,
  output logic                              pready,
  output logic                              pslverr,
  output logic [uart_pkg::period_width-1:0] period,
  output logic                              parity_en,
  input  logic                              parity_err,
  input  logic                              frame_err,
  input  logic                              rx_empty,
  input  uart_pkg::word_t                   rx_data,
  output logic                              rx_pop,
  input  logic                              tx_full,
  output logic                              tx_push,
  output uart_pkg::byte_t                   tx_data,
  input  logic                              tx_busy
);

  logic                              access;
  logic                              wr;
  logic                              rd;
  logic [31:0]                       rdata;
  logic [31:0]                       status;
  logic                              parity_err_q;
  logic                              frame_err_q;
  logic [uart_pkg::period_width-1:0] wr_period;

  assign access = psel && penable;
  assign wr     = access && pwrite;
  assign rd     = access && !pwrite;
  assign pready = 1'b1;

  assign rx_pop  = rd && (paddr == uart_pkg::addr_rxdata) && !rx_empty;
  assign tx_push = wr && (paddr == uart_pkg::addr_txdata) && !tx_full;
  assign tx_data = pwdata[uart_pkg::data_bits-1:0];

  assign pslverr = (rd && (paddr == uart_pkg::addr_rxdata) && rx_empty) ||
                   (wr && (paddr == uart_pkg::addr_txdata) && tx_full);

  assign wr_period = (pwdata[uart_pkg::period_width-1:0] < uart_pkg::min_period) ?
                     uart_pkg::min_period : pwdata[uart_pkg::period_width-1:0];

  always_comb
  begin
    status = '0;
    status[uart_pkg::stat_rx_avail]   = !rx_empty;
    status[uart_pkg::stat_tx_full]    = tx_full;
    status[uart_pkg::stat_tx_busy]    = tx_busy;
    status[uart_pkg::stat_parity_err] = parity_err_q;
    status[uart_pkg::stat_frame_err]  = frame_err_q;
  end

  always_comb
  begin
    rdata = '0;
    case (paddr)
      uart_pkg::addr_ctrl:   rdata[uart_pkg::ctrl_parity_en] = parity_en;
      uart_pkg::addr_period: rdata[uart_pkg::period_width-1:0] = period;
      uart_pkg::addr_status: rdata = status;
      uart_pkg::addr_rxdata: rdata = rx_empty ? '0 : rx_data;
      default:               rdata = '0;
    endcase
  end

  assign prdata = rd ? rdata : '0;

  always_ff @(posedge clk)
  begin
    if (!nrst)
    begin
      period       <= uart_pkg::default_period;
      parity_en    <= 1'b0;
      parity_err_q <= 1'b0;
      frame_err_q  <= 1'b0;
    end
    else
    begin
      if (wr && (paddr == uart_pkg::addr_ctrl))
        parity_en <= pwdata[uart_pkg::ctrl_parity_en];
      if (wr && (paddr == uart_pkg::addr_period))
        period <= wr_period;
      // a new error in the same cycle wins over the clear
      if (parity_err)
        parity_err_q <= 1'b1;
      else if (wr && (paddr == uart_pkg::addr_status) && pwdata[uart_pkg::stat_parity_err])
        parity_err_q <= 1'b0;
      if (frame_err)
        frame_err_q <= 1'b1;
      else if (wr && (paddr == uart_pkg::addr_status) && pwdata[uart_pkg::stat_frame_err])
        frame_err_q <= 1'b0;
    end
  end

endmodule

// ==== verilog/uart_pkg.sv ====
package uart_pkg;

  // frame and packing geometry
  localparam int data_bits  = 8;
  localparam int word_bytes = 4;

  localparam int period_width = 16;
  localparam logic [period_width-1:0] min_period     = 16'd4;
  localparam logic [period_width-1:0] default_period = 16'd16;

  localparam int rx_fifo_depth = 4;
  localparam int tx_fifo_depth = 4;

  localparam int addr_width = 5;
  localparam logic [addr_width-1:0] addr_ctrl   = 5'h00;
  localparam logic [addr_width-1:0] addr_period = 5'h04;
  localparam logic [addr_width-1:0] addr_status = 5'h08;
  localparam logic [addr_width-1:0] addr_rxdata = 5'h0C;
  localparam logic [addr_width-1:0] addr_txdata = 5'h10;

  // status register bit positions
  localparam int stat_rx_avail   = 0;
  localparam int stat_tx_full    = 1;
  localparam int stat_tx_busy    = 2;
  localparam int stat_parity_err = 3;
  localparam int stat_frame_err  = 4;

  localparam int ctrl_parity_en = 0;

  typedef logic [data_bits-1:0] byte_t;
  typedef logic [data_bits*word_bytes-1:0] word_t;

endpackage

// ==== verilog/uart_rx.sv ====
`timescale 1ns/1ns

module uart_rx (
  input  logic                              clk,
  input  logic                              nrst,
  input  logic                              rxd,
  input  logic [uart_pkg::period_width-1:0] period,
  input  logic                              parity_en,
  output logic                              byte_valid,
  output uart_pkg::byte_t                   byte_data,
  output logic                              parity_err,
  output logic                              frame_err
);

  localparam int idx_w    = $clog2(uart_pkg::data_bits);
  localparam int last_bit = uart_pkg::data_bits - 1;

  typedef enum logic [2:0] {
    st_idle,
    st_start,
    st_data,
    st_parity,
    st_stop
  } state_t;

  state_t                            state;
  logic [1:0]                        sync_q;
  logic                              rxd_prev;
  logic                              rxd_s;
  logic [uart_pkg::period_width-1:0] cnt;
  logic [idx_w-1:0]                  bit_idx;
  uart_pkg::byte_t                   shift_q;
  logic                              par_bit;
  logic                              bit_end;
  logic                              half_end;

  assign rxd_s     = sync_q[1];
  assign bit_end   = (cnt == period - 1'b1);
  assign half_end  = (cnt == (period >> 1) - 1'b1); // middle of the start bit
  assign byte_data = shift_q;

  always_ff @(posedge clk)
  begin
    if (!nrst)
    begin
      sync_q   <= 2'b11;
      rxd_prev <= 1'b1;
    end
    else
    begin
      sync_q   <= {sync_q[0], rxd};
      rxd_prev <= rxd_s;
    end
  end

  always_ff @(posedge clk)
  begin
    if (!nrst)
    begin
      state      <= st_idle;
      cnt        <= '0;
      bit_idx    <= '0;
      byte_valid <= 1'b0;
      parity_err <= 1'b0;
      frame_err  <= 1'b0;
    end
    else
    begin
      byte_valid <= 1'b0;
      parity_err <= 1'b0;
      frame_err  <= 1'b0;
      case (state)
        st_idle:
        begin
          cnt <= '0;
          if (rxd_prev && !rxd_s) // falling edge only, so a stuck low line is not a start
            state <= st_start;
        end
        st_start:
        begin
          if (half_end)
          begin
            cnt     <= '0;
            bit_idx <= '0;
            state   <= rxd_s ? st_idle : st_data; // glitch if the line went back high
          end
          else
            cnt <= cnt + 1'b1;
        end
        st_data:
        begin
          if (bit_end)
          begin
            cnt     <= '0;
            shift_q <= {rxd_s, shift_q[uart_pkg::data_bits-1:1]}; // lsb arrives first
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == idx_w'(last_bit))
              state <= parity_en ? st_parity : st_stop;
          end
          else
            cnt <= cnt + 1'b1;
        end
        st_parity:
        begin
          if (bit_end)
          begin
            cnt     <= '0;
            par_bit <= rxd_s;
            state   <= st_stop;
          end
          else
            cnt <= cnt + 1'b1;
        end
        st_stop:
        begin
          if (bit_end)
          begin
            cnt   <= '0;
            state <= st_idle;
            if (!rxd_s)
              frame_err <= 1'b1;
            else if (parity_en && ((^shift_q) != par_bit))
              parity_err <= 1'b1;
            else
              byte_valid <= 1'b1;
          end
          else
            cnt <= cnt + 1'b1;
        end
        default:
          state <= st_idle;
      endcase
    end
  end

endmodule

// ==== verilog/uart_top.sv ====
`timescale 1ns/1ns

module uart_top (
  input  logic                            clk,
  input  logic                            nrst,
  input  logic [uart_pkg::addr_width-1:0] paddr,
  input  logic                            psel,
  input  logic                            penable,
  input  logic                            pwrite,
  input  logic [31:0]                     pwdata,
  output logic [31:0]                     prdata,
  output logic                            pready,
  output logic                            pslverr,
  input  logic                            rxd,
  output logic                            txd
);

  logic [uart_pkg::period_width-1:0] period;
  logic                              parity_en;
  logic                              parity_err;
  logic                              frame_err;
  logic                              rx_empty;
  logic                              rx_pop;
  uart_pkg::word_t                   rx_data;
  logic                              tx_full;
  logic                              tx_empty;
  logic                              tx_push;
  logic                              tx_busy;
  uart_pkg::byte_t                   tx_data;
  uart_pkg::byte_t                   tx_head;
  logic                              byte_valid;
  uart_pkg::byte_t                   byte_data;
  logic                              word_valid;
  uart_pkg::word_t                   word_data;

  // hand the head byte to the transmitter as soon as it goes idle
  wire tx_load = !tx_busy && !tx_empty;

  uart_apb_regs i_regs (
    .clk        (clk),
    .nrst       (nrst),
    .paddr      (paddr),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .pwdata     (pwdata),
    .prdata     (prdata),
    .pready     (pready),
    .pslverr    (pslverr),
    .period     (period),
    .parity_en  (parity_en),
    .parity_err (parity_err),
    .frame_err  (frame_err),
    .rx_empty   (rx_empty),
    .rx_data    (rx_data),
    .rx_pop     (rx_pop),
    .tx_full    (tx_full),
    .tx_push    (tx_push),
    .tx_data    (tx_data),
    .tx_busy    (tx_busy)
  );

  sync_fifo #(
    .payload_t (uart_pkg::word_t),
    .depth     (uart_pkg::rx_fifo_depth)
  ) i_rx_fifo (
    .clk       (clk),
    .nrst      (nrst),
    .push      (word_valid),
    .push_data (word_data),
    .pop       (rx_pop),
    .pop_data  (rx_data),
    .empty     (rx_empty),
    .full      ()
  );

  sync_fifo #(
    .payload_t (uart_pkg::byte_t),
    .depth     (uart_pkg::tx_fifo_depth)
  ) i_tx_fifo (
    .clk       (clk),
    .nrst      (nrst),
    .push      (tx_push),
    .push_data (tx_data),
    .pop       (tx_load),
    .pop_data  (tx_head),
    .empty     (tx_empty),
    .full      (tx_full)
  );

  uart_rx i_rx (
    .clk        (clk),
    .nrst       (nrst),
    .rxd        (rxd),
    .period     (period),
    .parity_en  (parity_en),
    .byte_valid (byte_valid),
    .byte_data  (byte_data),
    .parity_err (parity_err),
    .frame_err  (frame_err)
  );

  uart_word_pack i_pack (
    .clk        (clk),
    .nrst       (nrst),
    .byte_valid (byte_valid),
    .byte_data  (byte_data),
    .word_valid (word_valid),
    .word_data  (word_data)
  );

  uart_tx i_tx (
    .clk       (clk),
    .nrst      (nrst),
    .period    (period),
    .parity_en (parity_en),
    .start     (tx_load),
    .data      (tx_head),
    .busy      (tx_busy),
    .txd       (txd)
  );

endmodule

// ==== verilog/uart_tx.sv ====
`timescale 1ns/1ns

module uart_tx (
  input  logic                              clk,
  input  logic                              nrst,
  input  logic [uart_pkg::period_width-1:0] period,
  input  logic                              parity_en,
  input  logic                              start,
  input  uart_pkg::byte_t                   data,
  output logic                              busy,
  output logic                              txd
);

  // stop, parity, data and start bits
  localparam int frame_w = uart_pkg::data_bits + 3;
  localparam int left_w  = $clog2(frame_w + 1);

  logic [frame_w-1:0]                shift_q;
  logic [left_w-1:0]                 bits_left;
  logic [uart_pkg::period_width-1:0] cnt;
  logic                              par_bit;

  assign par_bit = parity_en ? ^data : 1'b1; // even parity, idle level otherwise
  assign txd     = shift_q[0];

  always_ff @(posedge clk)
  begin
    if (!nrst)
    begin
      shift_q   <= '1;
      bits_left <= '0;
      cnt       <= '0;
      busy      <= 1'b0;
    end
    else if (!busy)
    begin
      if (start)
      begin
        shift_q   <= {1'b1, par_bit, data, 1'b0};
        bits_left <= parity_en ? left_w'(frame_w) : left_w'(frame_w - 1);
        cnt       <= '0;
        busy      <= 1'b1;
      end
    end
    else if (cnt == period - 1'b1)
    begin
      cnt       <= '0;
      shift_q   <= {1'b1, shift_q[frame_w-1:1]}; // ones fill in behind the frame
      bits_left <= bits_left - 1'b1;
      if (bits_left == left_w'(1))
        busy <= 1'b0;
    end
    else
      cnt <= cnt + 1'b1;
  end

endmodule

// ==== verilog/uart_word_pack.sv ====
`timescale 1ns/1ns

module uart_word_pack (
  input  logic            clk,
  input  logic            nrst,
  input  logic            byte_valid,
  input  uart_pkg::byte_t byte_data,
  output logic            word_valid,
  output uart_pkg::word_t word_data
);

  localparam int cnt_w = $clog2(uart_pkg::word_bytes);
  localparam int dw    = uart_pkg::data_bits;

  logic [cnt_w-1:0] byte_cnt;
  uart_pkg::word_t  shift_q;

  // each new byte enters at the top, so after four bytes byte 0 sits in the low bits
  assign word_data = shift_q;

  always_ff @(posedge clk)
  begin
    if (byte_valid)
      shift_q <= {byte_data, shift_q[$bits(shift_q)-1:dw]};
  end

  always_ff @(posedge clk)
  begin
    if (!nrst)
    begin
      byte_cnt   <= '0;
      word_valid <= 1'b0;
    end
    else
    begin
      word_valid <= 1'b0;
      if (byte_valid)
      begin
        byte_cnt <= byte_cnt + 1'b1; // wraps to zero after the last byte
        if (byte_cnt == cnt_w'(uart_pkg::word_bytes - 1))
          word_valid <= 1'b1;
      end
    end
  end

endmodule
